// File: rob_top.f
rtl/rob_pkg.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_entry_array.sv
rtl/rob_commit_fsm.sv
rtl/rob_top.sv
tb/rob_tb.sv

// File: rtl/rob_commit_fsm.sv
`timescale 1ns/10ps

module rob_commit_fsm
    import rob_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 empty,
    input  logic [rob_idx_w-1:0] head,
    input  logic                 head_done,
    input  logic [kind_w-1:0]    head_kind,
    input  logic [reg_w-1:0]     head_rd,
    input  logic                 head_pred,
    input  logic                 head_taken,
    input  rob_result_u          head_result,
    input  logic                 store_done,
    output logic                 retire,
    output logic                 flush_clr,
    output logic                 commit_en,
    output logic [reg_w-1:0]     commit_rd,
    output logic [data_w-1:0]    commit_value,
    output logic [rob_idx_w-1:0] commit_tag,
    output logic                 store_go,
    output logic [rob_idx_w-1:0] store_tag,
    output logic                 flush,
    output logic [data_w-1:0]    redirect_pc,
    output logic                 flushing
);

    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_store_wait = 2'd1;
    localparam logic [1:0] st_flush      = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       head_ready;
    logic       is_alu;
    logic       is_branch;
    logic       is_store;
    logic       mispredict;

    // head can only act from idle once its result is in
    assign head_ready = (state == st_idle) && !empty && head_done;

    assign is_alu     = (head_kind == kind_alu);
    assign is_branch  = (head_kind == kind_branch);
    assign is_store   = (head_kind == kind_store);
    assign mispredict = is_branch && (head_taken != head_pred);

    assign commit_en = head_ready && is_alu;
    assign store_go  = head_ready && is_store;
    assign flush     = head_ready && mispredict;
    assign flush_clr = flush;
    assign flushing  = (state == st_flush);

    // alu and good branches retire at once, stores wait for the ack
    assign retire = (head_ready && (is_alu || (is_branch && !mispredict)))
                 || ((state == st_store_wait) && store_done);

    // same result word, read per kind
    assign commit_value = head_result.value;
    assign redirect_pc  = head_result.next_pc;
    assign commit_rd    = head_rd;
    assign commit_tag   = head;
    assign store_tag    = head;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (store_go) begin
                    state_nxt = st_store_wait;
                end else if (flush) begin
                    state_nxt = st_flush;
                end
            end
            st_store_wait: begin
                if (store_done) begin
                    state_nxt = st_idle;
                end
            end
            st_flush: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // store buffer only acks a store that was handed to it
    a_store_done_in_wait : assert property (
        @(posedge clk) disable iff (!arst_n)
        store_done |-> (state == st_store_wait)
    ) else $error("store_done outside the store wait");

endmodule

// File: rtl/rob_entry_array.sv
`timescale 1ns/10ps

module rob_entry_array
    import rob_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    // allocation from the front end
    input  logic                 alloc_we,
    input  logic [rob_idx_w-1:0] alloc_idx,
    input  logic [kind_w-1:0]    alloc_kind,
    input  logic [reg_w-1:0]     alloc_rd,
    input  logic                 alloc_pred_taken,
    // writeback from execution
    input  logic                 wb_en,
    input  logic [rob_idx_w-1:0] wb_tag,
    input  rob_result_u          wb_result,
    input  logic                 wb_taken,
    // head read port
    input  logic [rob_idx_w-1:0] head,
    input  logic                 flush_clr,
    output logic                 head_done,
    output logic [kind_w-1:0]    head_kind,
    output logic [reg_w-1:0]     head_rd,
    output logic                 head_pred,
    output logic                 head_taken,
    output rob_result_u          head_result
);

    // done bits carry control state, the rest is payload
    logic [rob_depth-1:0] done;

    logic [kind_w-1:0] kind_mem   [rob_depth];
    logic [reg_w-1:0]  rd_mem     [rob_depth];
    logic              pred_mem   [rob_depth];
    logic              taken_mem  [rob_depth];
    rob_result_u       result_mem [rob_depth];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= '0;
        end else if (flush_clr) begin
            // wipes the wrong path as well as the flushing branch
            done <= '0;
        end else begin
            if (alloc_we) begin
                done[alloc_idx] <= 1'b0;
            end
            if (wb_en) begin
                done[wb_tag] <= 1'b1;
            end
        end
    end

    // static fields, fixed at allocation
    always_ff @(posedge clk) begin
        if (alloc_we) begin
            kind_mem[alloc_idx] <= alloc_kind;
            rd_mem[alloc_idx]   <= alloc_rd;
            pred_mem[alloc_idx] <= alloc_pred_taken;
        end
    end

    // results arrive by tag, in any order
    always_ff @(posedge clk) begin
        if (wb_en) begin
            result_mem[wb_tag] <= wb_result;
            taken_mem[wb_tag]  <= wb_taken;
        end
    end

    assign head_done   = done[head];
    assign head_kind   = kind_mem[head];
    assign head_rd     = rd_mem[head];
    assign head_pred   = pred_mem[head];
    assign head_taken  = taken_mem[head];
    assign head_result = result_mem[head];

    // each tag is written back once per allocation
    a_single_writeback : assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_en |-> !done[wb_tag]
    ) else $error("second writeback to tag %0d", wb_tag);

endmodule

// File: rtl/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;

    // datapath widths
    localparam int data_w = 32;
    localparam int reg_w  = 5;
    localparam int kind_w = 2;

    // entry kinds, set by the front end at allocation
    localparam logic [kind_w-1:0] kind_alu    = 2'd0;
    localparam logic [kind_w-1:0] kind_branch = 2'd1;
    localparam logic [kind_w-1:0] kind_store  = 2'd2;

    // word written back by execution
    // alu entries carry the register result, branches the resolved next pc
    typedef union packed {
        logic [data_w-1:0] value;
        logic [data_w-1:0] next_pc;
    } rob_result_u;

endpackage

// File: rtl/rob_ptr_ctrl.sv
`timescale 1ns/10ps

module rob_ptr_ctrl
    import rob_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 alloc_en,
    input  logic                 retire,
    input  logic                 flush_clr,
    output logic [rob_idx_w-1:0] head,
    output logic [rob_idx_w-1:0] tail,
    output logic                 full,
    output logic                 empty
);

    // one extra bit so that 16 entries can be told from none
    logic [rob_idx_w:0] count;
    logic               push;
    logic               pop;

    assign push = alloc_en && (count < rob_depth);
    assign pop  = retire;

    assign full  = (count == rob_depth);
    assign empty = (count == '0);

    // pointers wrap on their own at the buffer depth
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else if (flush_clr) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (flush_clr) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                // push and pop together leave the count alone
                default: count <= count;
            endcase
        end
    end

    // the commit side must only retire an occupied head
    a_no_retire_when_empty : assert property (
        @(posedge clk) disable iff (!arst_n)
        retire |-> !empty
    ) else $error("retire while the buffer is empty");

endmodule

// File: rtl/rob_top.sv
`timescale 1ns/10ps

module rob_top
    import rob_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    // allocation
    input  logic                 alloc_en,
    input  logic [kind_w-1:0]    alloc_kind,
    input  logic [reg_w-1:0]     alloc_rd,
    input  logic                 alloc_pred_taken,
    output logic [rob_idx_w-1:0] alloc_tag,
    output logic                 full,
    // writeback
    input  logic                 wb_en,
    input  logic [rob_idx_w-1:0] wb_tag,
    input  rob_result_u          wb_result,
    input  logic                 wb_taken,
    // store buffer
    output logic                 store_go,
    output logic [rob_idx_w-1:0] store_tag,
    input  logic                 store_done,
    // commit and redirect
    output logic                 commit_en,
    output logic [reg_w-1:0]     commit_rd,
    output logic [data_w-1:0]    commit_value,
    output logic [rob_idx_w-1:0] commit_tag,
    output logic                 flush,
    output logic [data_w-1:0]    redirect_pc
);

    logic [rob_idx_w-1:0] head;
    logic [rob_idx_w-1:0] tail;
    logic                 ptr_full;
    logic                 empty;
    logic                 retire;
    logic                 flush_clr;
    logic                 flushing;
    logic                 alloc_ok;

    logic                 head_done;
    logic [kind_w-1:0]    head_kind;
    logic [reg_w-1:0]     head_rd;
    logic                 head_pred;
    logic                 head_taken;
    rob_result_u          head_result;

    // no wrong-path allocation while the flush settles
    assign full      = ptr_full || flushing;
    assign alloc_ok  = alloc_en && !full;
    assign alloc_tag = tail;

    rob_ptr_ctrl u_ptr (
        .clk       (clk),
        .arst_n    (arst_n),
        .alloc_en  (alloc_ok),
        .retire    (retire),
        .flush_clr (flush_clr),
        .head      (head),
        .tail      (tail),
        .full      (ptr_full),
        .empty     (empty)
    );

    rob_entry_array u_array (
        .clk              (clk),
        .arst_n           (arst_n),
        .alloc_we         (alloc_ok),
        .alloc_idx        (tail),
        .alloc_kind       (alloc_kind),
        .alloc_rd         (alloc_rd),
        .alloc_pred_taken (alloc_pred_taken),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_result        (wb_result),
        .wb_taken         (wb_taken),
        .head             (head),
        .flush_clr        (flush_clr),
        .head_done        (head_done),
        .head_kind        (head_kind),
        .head_rd          (head_rd),
        .head_pred        (head_pred),
        .head_taken       (head_taken),
        .head_result      (head_result)
    );

    rob_commit_fsm u_commit (
        .clk          (clk),
        .arst_n       (arst_n),
        .empty        (empty),
        .head         (head),
        .head_done    (head_done),
        .head_kind    (head_kind),
        .head_rd      (head_rd),
        .head_pred    (head_pred),
        .head_taken   (head_taken),
        .head_result  (head_result),
        .store_done   (store_done),
        .retire       (retire),
        .flush_clr    (flush_clr),
        .commit_en    (commit_en),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag),
        .store_go     (store_go),
        .store_tag    (store_tag),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .flushing     (flushing)
    );

    // front end should hold off while full, the request is dropped
    a_alloc_not_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        alloc_en |-> !full
    ) else $warning("allocation requested while full, not taken");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator.
# The exit status is nonzero when the testbench reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rob_tb \
    -f rob_top.f \
    -o rob_sim

./obj_dir/rob_sim

// File: tb/rob_tb.sv
`timescale 1ns/10ps

module rob_tb
    import rob_pkg::*;
();

    localparam int act_none   = 0;
    localparam int act_write  = 1;
    localparam int act_silent = 2;
    localparam int act_store  = 3;
    localparam int act_flush  = 4;

    typedef struct packed {
        logic [rob_idx_w-1:0] tag;
        logic [kind_w-1:0]    kind;
        logic [reg_w-1:0]     rd;
        logic                 pred;
    } entry_t;

    logic                 clk;
    logic                 arst_n;
    logic                 alloc_en;
    logic [kind_w-1:0]    alloc_kind;
    logic [reg_w-1:0]     alloc_rd;
    logic                 alloc_pred_taken;
    logic [rob_idx_w-1:0] alloc_tag;
    logic                 full;
    logic                 wb_en;
    logic [rob_idx_w-1:0] wb_tag;
    rob_result_u          wb_result;
    logic                 wb_taken;
    logic                 store_go;
    logic [rob_idx_w-1:0] store_tag;
    logic                 store_done;
    logic                 commit_en;
    logic [reg_w-1:0]     commit_rd;
    logic [data_w-1:0]    commit_value;
    logic [rob_idx_w-1:0] commit_tag;
    logic                 flush;
    logic [data_w-1:0]    redirect_pc;

    // reference model state kept by the monitor
    entry_t               ref_q[$];
    logic [rob_depth-1:0] done_m;
    logic [data_w-1:0]    res_m [rob_depth];
    logic                 tk_m  [rob_depth];
    logic [rob_idx_w-1:0] exp_tail;
    logic                 waiting;
    logic                 flush_cyc;
    int                   n_flush;

    logic [31:0]          lfsr_state = 32'hfed4;
    logic [rob_idx_w-1:0] pend[$];
    int                   ops_issued;
    int                   errors;

    rob_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    // what the oldest entry should do once its result is in
    function automatic int ref_retire(input entry_t e, input logic [data_w-1:0] result,
                                      input logic taken, output logic [reg_w-1:0] rd,
                                      output logic [data_w-1:0] word,
                                      output logic [rob_idx_w-1:0] tag);
        rd   = e.rd;
        word = result;
        tag  = e.tag;
        if (e.kind == kind_alu) begin
            return act_write;
        end else if (e.kind == kind_store) begin
            return act_store;
        end else if (taken == e.pred) begin
            return act_silent;
        end
        return act_flush;
    endfunction

    always @(posedge clk) begin : monitor
        entry_t               nw;
        int                   act;
        logic [reg_w-1:0]     e_rd;
        logic [data_w-1:0]    e_word;
        logic [rob_idx_w-1:0] e_tag;
        logic                 exp_full;
        if (arst_n) begin
            exp_full = (ref_q.size() == rob_depth) || flush_cyc;
            act = act_none;
            if (!waiting && !flush_cyc && ref_q.size() != 0 && done_m[ref_q[0].tag]) begin
                act = ref_retire(ref_q[0], res_m[ref_q[0].tag], tk_m[ref_q[0].tag],
                                 e_rd, e_word, e_tag);
            end
            check_eq(full, exp_full, "full");
            check_eq(alloc_tag, exp_tail, "alloc_tag");
            check_eq(commit_en, act == act_write, "commit_en");
            check_eq(store_go, act == act_store, "store_go");
            check_eq(flush, act == act_flush, "flush");
            if (act == act_write) begin
                check_eq(commit_rd, e_rd, "commit_rd");
                check_eq(commit_value, e_word, "commit_value");
                check_eq(commit_tag, e_tag, "commit_tag");
            end
            if (act == act_store) begin
                check_eq(store_tag, e_tag, "store_tag");
            end
            if (act == act_flush) begin
                check_eq(redirect_pc, e_word, "redirect_pc");
            end
            flush_cyc = 1'b0;
            if (alloc_en && !exp_full) begin
                nw.tag  = exp_tail;
                nw.kind = alloc_kind;
                nw.rd   = alloc_rd;
                nw.pred = alloc_pred_taken;
                ref_q.push_back(nw);
                done_m[exp_tail] = 1'b0;
                exp_tail = exp_tail + 1'b1;
            end
            if (wb_en) begin
                done_m[wb_tag] = 1'b1;
                res_m[wb_tag]  = wb_result;
                tk_m[wb_tag]   = wb_taken;
            end
            if (act == act_write || act == act_silent || (waiting && store_done)) begin
                ref_q.delete(0);
                waiting = 1'b0;
            end
            if (act == act_store) begin
                waiting = 1'b1;
            end
            if (act == act_flush) begin
                ref_q.delete();
                done_m    = '0;
                exp_tail  = '0;
                flush_cyc = 1'b1;
                n_flush++;
            end
        end
    end

    // store buffer stand-in that acks after a random delay
    initial begin : store_ack
        int delay;
        store_done = 1'b0;
        forever begin
            @(posedge clk);
            if (arst_n && store_go) begin
                delay = int'(rand_bits(3));
                @(negedge clk);
                repeat (delay) @(negedge clk);
                store_done = 1'b1;
                @(negedge clk);
                store_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 20 * ops_issued + 200) begin
                $display("timeout: run did not finish within %0d cycles", cycles);
                $display("=== FAIL ===");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic alloc_entry(input logic [kind_w-1:0] kind, input logic pred,
                               output logic [rob_idx_w-1:0] tag);
        while (full) @(negedge clk);
        alloc_en         = 1'b1;
        alloc_kind       = kind;
        alloc_rd         = reg_w'(rand_bits(reg_w));
        alloc_pred_taken = pred;
        tag = alloc_tag;
        ops_issued++;
        @(negedge clk);
        alloc_en = 1'b0;
    endtask

    task automatic write_back(input logic [rob_idx_w-1:0] tag, input logic taken);
        wb_en           = 1'b1;
        wb_tag          = tag;
        wb_result.value = rand_bits(data_w);
        wb_taken        = taken;
        ops_issued++;
        @(negedge clk);
        wb_en = 1'b0;
    endtask

    // writes back all pending alu tags in shuffled order
    task automatic shuffle_and_write();
        logic [rob_idx_w-1:0] t;
        int                   i;
        int                   j;
        for (i = pend.size() - 1; i > 0; i--) begin
            j = int'(rand_bits(4)) % (i + 1);
            t = pend[i];
            pend[i] = pend[j];
            pend[j] = t;
        end
        while (pend.size() != 0) begin
            write_back(pend.pop_front(), 1'b0);
        end
    endtask

    task automatic drain();
        while (ref_q.size() != 0 || waiting || flush_cyc) @(negedge clk);
    endtask

    initial begin : stimulus
        logic [rob_idx_w-1:0] tag;
        logic [rob_idx_w-1:0] st;
        logic [rob_idx_w-1:0] br;
        logic [rob_idx_w-1:0] a1;
        logic [rob_idx_w-1:0] a2;
        logic                 pred;
        int                   flushes_before;
        arst_n = 1'b0;
        alloc_en = 1'b0;
        alloc_kind = kind_alu;
        alloc_rd = '0;
        alloc_pred_taken = 1'b0;
        wb_en = 1'b0;
        wb_tag = '0;
        wb_result = '0;
        wb_taken = 1'b0;
        ref_q.delete();
        done_m = '0;
        exp_tail = '0;
        waiting = 1'b0;
        flush_cyc = 1'b0;
        n_flush = 0;
        ops_issued = 0;
        errors = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // a few idle cycles after reset
        repeat (4) @(negedge clk);

        // three rounds of shuffled alu writebacks so the tags wrap
        repeat (3) begin
            repeat (8) begin
                alloc_entry(kind_alu, 1'b0, tag);
                pend.push_back(tag);
            end
            shuffle_and_write();
            drain();
        end

        // fill up, then try one more
        repeat (rob_depth) begin
            alloc_entry(kind_alu, 1'b0, tag);
            pend.push_back(tag);
        end
        check_eq(full, 1'b1, "full after 16 allocations");
        alloc_en = 1'b1;
        @(negedge clk);
        alloc_en = 1'b0;
        // the tail has wrapped back to the first tag of this batch
        check_eq(alloc_tag, pend[0], "alloc_tag after refused allocation");
        shuffle_and_write();
        drain();

        // stores block younger entries until acked
        repeat (4) begin
            alloc_entry(kind_store, 1'b0, st);
            alloc_entry(kind_alu, 1'b0, a1);
            alloc_entry(kind_alu, 1'b0, a2);
            write_back(a2, 1'b0);
            write_back(a1, 1'b0);
            write_back(st, 1'b0);
            alloc_entry(kind_alu, 1'b0, a1);
            write_back(a1, 1'b0);
            drain();
        end

        // correctly predicted branches
        repeat (2) begin
            pred = 1'(rand_bits(1));
            alloc_entry(kind_branch, pred, br);
            alloc_entry(kind_alu, 1'b0, a1);
            alloc_entry(kind_alu, 1'b0, a2);
            write_back(a2, 1'b0);
            write_back(a1, 1'b0);
            write_back(br, pred);
            drain();
        end

        // mispredicted branch with finished younger entries behind it
        pred = 1'(rand_bits(1));
        alloc_entry(kind_branch, pred, br);
        alloc_entry(kind_alu, 1'b0, a1);
        alloc_entry(kind_alu, 1'b0, a2);
        write_back(a1, 1'b0);
        write_back(a2, 1'b0);
        flushes_before = n_flush;
        write_back(br, !pred);
        while (n_flush == flushes_before) @(negedge clk);
        alloc_entry(kind_alu, 1'b0, tag);
        check_eq(tag, 0, "first tag after flush");
        write_back(tag, 1'b0);
        drain();
        repeat (4) @(negedge clk);

        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "errors seen");
        end
    end

endmodule
